// ==== verilog/stride_pkg.sv ====
package stride_pkg;

    // ----------------------------------------------------------
    // Widths and sizing
    // ----------------------------------------------------------
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int SEQ_W       = 8;

    // Headroom between threshold and depth covers words in flight
    localparam int FIFO_DEPTH  = 16;
    localparam int PTR_W       = $clog2(FIFO_DEPTH);
    localparam int PROG_THRESH = 8;

    // Byte size of one index element
    localparam int ELEM_BYTES  = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [PTR_W:0]    fifo_cnt_t;

    // ----------------------------------------------------------
    // Configuration and packets
    // ----------------------------------------------------------
    typedef struct packed {
        logic [15:0] start;
        logic [7:0]  stride;
        logic [7:0]  count;
    } stride_cfg_t;

    // Raw view for storage, cfg view for decode
    typedef union packed {
        logic [DATA_W-1:0] raw;
        stride_cfg_t       cfg;
    } resp_word_u;

    typedef struct packed {
        logic       valid;
        resp_word_u word;
    } response_packet_t;

    typedef struct packed {
        logic  valid;
        addr_t base_address;
    } descriptor_t;

    typedef struct packed {
        logic [SEQ_W-1:0] seq;
        addr_t            address;
    } request_payload_t;

    typedef struct packed {
        logic             valid;
        request_payload_t payload;
    } request_packet_t;

endpackage

// ==== verilog/stride_fifo.sv ====
`timescale 1ns/1ns

module stride_fifo #(
    parameter int WIDTH = stride_pkg::DATA_W
) (
    input  logic             ap_clk,
    input  logic             areset_csr_engine,
    input  logic             wr_en_i,
    input  logic [WIDTH-1:0] din_i,
    input  logic             rd_en_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             empty_o,
    output logic             full_o,
    output logic             prog_full_o
);

    logic [WIDTH-1:0]             mem [0:stride_pkg::FIFO_DEPTH-1];
    logic [stride_pkg::PTR_W-1:0] wr_ptr_q;
    logic [stride_pkg::PTR_W-1:0] rd_ptr_q;
    stride_pkg::fifo_cnt_t        count_q;

    // Storage array
    always_ff @(posedge ap_clk) begin
        if (wr_en_i) begin
            mem[wr_ptr_q] <= din_i;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en_i, rd_en_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head entry is always presented
    assign dout_o      = mem[rd_ptr_q];
    assign empty_o     = (count_q == '0);
    assign full_o      = (count_q == stride_pkg::fifo_cnt_t'(stride_pkg::FIFO_DEPTH));
    assign prog_full_o = (count_q >= stride_pkg::fifo_cnt_t'(stride_pkg::PROG_THRESH));

    // ----------------------------------------------------------
    // Caller protocol
    // ----------------------------------------------------------
    a_no_push_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        full_o |-> !wr_en_i
    ) else $error("stride_fifo push while full");

    a_no_pop_when_empty : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        empty_o |-> !rd_en_i
    ) else $error("stride_fifo pop while empty");

endmodule

// ==== verilog/stride_configure.sv ====
`timescale 1ns/1ns

module stride_configure (
    input  logic                    ap_clk,
    input  logic                    areset_csr_engine,
    input  stride_pkg::resp_word_u  resp_word_i,
    input  logic                    resp_empty_i,
    input  logic                    cfg_take_i,
    output logic                    resp_rd_en_o,
    output stride_pkg::stride_cfg_t cfg_o,
    output logic                    cfg_valid_o
);

    stride_pkg::stride_cfg_t cfg_q;
    logic                    cfg_valid_q;
    logic                    capture;

    // Next word is popped only into a free slot
    assign capture      = ~resp_empty_i & ~cfg_valid_q;
    assign resp_rd_en_o = capture;

    // Slot occupancy
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_valid_q <= 1'b0;
        end else if (capture) begin
            cfg_valid_q <= 1'b1;
        end else if (cfg_take_i) begin
            cfg_valid_q <= 1'b0;
        end
    end

    // Decode through the configuration view of the word
    always_ff @(posedge ap_clk) begin
        if (capture) begin
            cfg_q <= resp_word_i.cfg;
        end
    end

    assign cfg_o       = cfg_q;
    assign cfg_valid_o = cfg_valid_q;

    // Generator may only take a configuration that is held
    a_take_needs_valid : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        cfg_take_i |-> cfg_valid_o
    ) else $error("stride_configure take without a held configuration");

endmodule

// ==== verilog/stride_generator.sv ====
`timescale 1ns/1ns

module stride_generator (
    input  logic                         ap_clk,
    input  logic                         areset_csr_engine,
    input  logic                         start_i,
    input  stride_pkg::addr_t            base_address_i,
    input  stride_pkg::stride_cfg_t      cfg_i,
    input  logic                         cfg_valid_i,
    input  logic                         stall_i,
    output logic                         cfg_take_o,
    output logic                         req_push_o,
    output stride_pkg::request_payload_t req_payload_o,
    output logic                         busy_o
);

    typedef enum logic {
        GEN_IDLE,
        GEN_RUN
    } gen_state_e;

    gen_state_e                   state_q;
    stride_pkg::addr_t            base_q;
    stride_pkg::addr_t            index_q;
    logic [15:0]                  start_q;
    logic [7:0]                   stride_q;
    logic [7:0]                   remaining_q;
    logic [stride_pkg::SEQ_W-1:0] seq_q;
    logic                         launch;

    // Descriptor and configuration are consumed together
    assign launch     = (state_q == GEN_IDLE) & start_i & cfg_valid_i;
    assign cfg_take_o = launch;

    assign req_push_o = (state_q == GEN_RUN) & (remaining_q != '0) & ~stall_i;
    assign busy_o     = (state_q == GEN_RUN);

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state_q     <= GEN_IDLE;
            remaining_q <= '0;
            seq_q       <= '0;
        end else begin
            case (state_q)
                GEN_IDLE: begin
                    if (launch) begin
                        state_q     <= GEN_RUN;
                        remaining_q <= cfg_i.count;
                        seq_q       <= '0;
                    end
                end
                GEN_RUN: begin
                    // Zero count falls straight back to idle
                    if (remaining_q == '0) begin
                        state_q <= GEN_IDLE;
                    end else if (req_push_o) begin
                        remaining_q <= remaining_q - 1'b1;
                        seq_q       <= seq_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= GEN_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Running index
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (launch) begin
            base_q   <= base_address_i;
            start_q  <= cfg_i.start;
            index_q  <= stride_pkg::addr_t'(cfg_i.start);
            stride_q <= cfg_i.stride;
        end else if (req_push_o) begin
            index_q <= index_q + stride_pkg::addr_t'(stride_q);
        end
    end

    // Element index scaled to bytes
    assign req_payload_o.seq     = seq_q;
    assign req_payload_o.address = base_q
                                 + index_q * stride_pkg::addr_t'(stride_pkg::ELEM_BYTES);

    // Running sum stays equal to start plus tag times stride
    a_index_tracks_seq : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        busy_o |-> (index_q == stride_pkg::addr_t'(start_q)
                             + stride_pkg::addr_t'(seq_q) * stride_pkg::addr_t'(stride_q))
    ) else $error("stride_generator running index out of step with the sequence tag");

endmodule

// ==== verilog/engine_stride_index.sv ====
`timescale 1ns/1ns

module engine_stride_index (
    input  logic                         ap_clk,
    input  logic                         areset_csr_engine,
    input  stride_pkg::descriptor_t      descriptor_i,
    input  stride_pkg::response_packet_t response_memory_i,
    input  logic                         request_rd_en_i,
    output logic                         response_ready_o,
    output stride_pkg::request_packet_t  request_memory_o,
    output logic                         done_o
);

    logic                         reset_q;
    stride_pkg::descriptor_t      descriptor_q;
    stride_pkg::response_packet_t response_q;
    logic                         request_rd_en_q;

    stride_pkg::addr_t            base_q;
    logic                         pending_q;
    logic                         busy_q;
    logic                         done_int;

    stride_pkg::resp_word_u       resp_fifo_word;
    logic                         resp_fifo_rd_en;
    logic                         resp_fifo_empty;
    logic                         resp_fifo_prog_full;

    stride_pkg::stride_cfg_t      cfg;
    logic                         cfg_valid;
    logic                         cfg_take;

    logic                         gen_push;
    stride_pkg::request_payload_t gen_payload;
    logic                         gen_busy;

    stride_pkg::request_payload_t req_fifo_dout;
    logic                         req_fifo_rd_en;
    logic                         req_fifo_empty;
    logic                         req_fifo_prog_full;

    // ----------------------------------------------------------
    // Input registers
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        reset_q <= areset_csr_engine;
    end

    always_ff @(posedge ap_clk) begin
        if (reset_q) begin
            descriptor_q.valid <= 1'b0;
            response_q.valid   <= 1'b0;
            request_rd_en_q    <= 1'b0;
        end else begin
            descriptor_q.valid <= descriptor_i.valid;
            response_q.valid   <= response_memory_i.valid;
            request_rd_en_q    <= request_rd_en_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_q.base_address <= descriptor_i.base_address;
        response_q.word           <= response_memory_i.word;
    end

    // Descriptor waits here until the generator starts on it
    always_ff @(posedge ap_clk) begin
        if (reset_q) begin
            pending_q <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            busy_q <= gen_busy;
            if (descriptor_q.valid) begin
                pending_q <= 1'b1;
            end else if (gen_busy && !busy_q) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (descriptor_q.valid) begin
            base_q <= descriptor_q.base_address;
        end
    end

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------
    stride_fifo #(
        .WIDTH(stride_pkg::DATA_W)
    ) u_resp_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(reset_q),
        .wr_en_i          (response_q.valid),
        .din_i            (response_q.word.raw),
        .rd_en_i          (resp_fifo_rd_en),
        .dout_o           (resp_fifo_word.raw),
        .empty_o          (resp_fifo_empty),
        .full_o           (),
        .prog_full_o      (resp_fifo_prog_full)
    );

    stride_configure u_configure (
        .ap_clk           (ap_clk),
        .areset_csr_engine(reset_q),
        .resp_word_i      (resp_fifo_word),
        .resp_empty_i     (resp_fifo_empty),
        .cfg_take_i       (cfg_take),
        .resp_rd_en_o     (resp_fifo_rd_en),
        .cfg_o            (cfg),
        .cfg_valid_o      (cfg_valid)
    );

    stride_generator u_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(reset_q),
        .start_i          (pending_q),
        .base_address_i   (base_q),
        .cfg_i            (cfg),
        .cfg_valid_i      (cfg_valid),
        .stall_i          (req_fifo_prog_full),
        .cfg_take_o       (cfg_take),
        .req_push_o       (gen_push),
        .req_payload_o    (gen_payload),
        .busy_o           (gen_busy)
    );

    // Consumer pops with its registered read enable
    assign req_fifo_rd_en = ~req_fifo_empty & request_rd_en_q;

    stride_fifo #(
        .WIDTH($bits(stride_pkg::request_payload_t))
    ) u_req_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(reset_q),
        .wr_en_i          (gen_push),
        .din_i            (gen_payload),
        .rd_en_i          (req_fifo_rd_en),
        .dout_o           (req_fifo_dout),
        .empty_o          (req_fifo_empty),
        .full_o           (),
        .prog_full_o      (req_fifo_prog_full)
    );

    // Idle with nothing queued, pending or still on the output
    assign done_int = ~gen_busy & ~pending_q & ~descriptor_q.valid
                    & req_fifo_empty & ~request_memory_o.valid;

    // ----------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset_q) begin
            response_ready_o       <= 1'b1;
            request_memory_o.valid <= 1'b0;
            done_o                 <= 1'b1;
        end else begin
            response_ready_o       <= ~resp_fifo_prog_full;
            request_memory_o.valid <= req_fifo_rd_en;
            done_o                 <= done_int;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_memory_o.payload <= req_fifo_dout;
    end

    a_desc_only_when_done : assert property (
        @(posedge ap_clk) disable iff (reset_q)
        descriptor_i.valid |-> done_o
    ) else $error("engine_stride_index descriptor received while busy");

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic ap_clk_o,
    output logic areset_o
);

    initial begin
        ap_clk_o = 1'b0;
        forever #(PERIOD_NS / 2) ap_clk_o = ~ap_clk_o;
    end

    // Reset released on a rising edge
    initial begin
        areset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk_o);
        areset_o <= 1'b0;
    end

endmodule

// ==== testbench/tb_engine_stride_index.sv ====
`timescale 1ns/1ns

module tb_engine_stride_index;

    // Five runs of up to 255 requests at half throughput, doubled for margin
    localparam int MAX_RUNS       = 5;
    localparam int MAX_COUNT      = 255;
    localparam int TIMEOUT_CYCLES = MAX_RUNS * MAX_COUNT * 4 + 900;

    logic                         ap_clk;
    logic                         areset_csr_engine;
    stride_pkg::descriptor_t      descriptor_i;
    stride_pkg::response_packet_t response_memory_i;
    logic                         request_rd_en_i;
    logic                         response_ready_o;
    stride_pkg::request_packet_t  request_memory_o;
    logic                         done_o;

    stride_pkg::request_payload_t expected_q[$];
    stride_pkg::request_payload_t exp_head = '0;
    int                           exp_count = 0;
    int                           cycle_count = 0;
    logic                         rd_random = 1'b0;

    tb_clock_gen #(
        .PERIOD_NS   (100),
        .RESET_CYCLES(2)
    ) u_clock_gen (
        .ap_clk_o(ap_clk),
        .areset_o(areset_csr_engine)
    );

    engine_stride_index dut_i (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .descriptor_i     (descriptor_i),
        .response_memory_i(response_memory_i),
        .request_rd_en_i  (request_rd_en_i),
        .response_ready_o (response_ready_o),
        .request_memory_o (request_memory_o),
        .done_o           (done_o)
    );

    // ----------------------------------------------------------
    // Reporting
    // ----------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        fail_run($sformatf("FAIL at %0t ns: %s = 0x%0h, expected 0x%0h",
                           $time, name, got, expected));
    endtask

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------
    // One clock, with the consumer read enable for the next cycle
    task automatic tick();
        @(posedge ap_clk);
        if (rd_random) begin
            request_rd_en_i <= ($urandom_range(1, 0) == 1);
        end else begin
            request_rd_en_i <= 1'b1;
        end
    endtask

    function automatic stride_pkg::stride_cfg_t make_cfg(input int start, input int stride,
                                                         input int count);
        stride_pkg::stride_cfg_t cfg;
        cfg.start  = 16'(start);
        cfg.stride = 8'(stride);
        cfg.count  = 8'(count);
        return cfg;
    endfunction

    task automatic send_config(input stride_pkg::stride_cfg_t cfg);
        stride_pkg::response_packet_t pkt;
        pkt.valid    = 1'b1;
        pkt.word.cfg = cfg;
        tick();
        while (!response_ready_o) tick();
        response_memory_i <= pkt;
        tick();
        response_memory_i.valid <= 1'b0;
    endtask

    // Address rule is base + (start + k*stride) * element size
    task automatic queue_expected(input stride_pkg::addr_t base,
                                  input stride_pkg::stride_cfg_t cfg);
        stride_pkg::request_payload_t req;
        logic [31:0]                  index;
        for (int k = 0; k < int'(cfg.count); k++) begin
            index       = 32'(cfg.start) + 32'(k) * 32'(cfg.stride);
            req.seq     = 8'(k);
            req.address = base + index * 32'(stride_pkg::ELEM_BYTES);
            expected_q.push_back(req);
        end
    endtask

    task automatic send_descriptor(input stride_pkg::addr_t base);
        tick();
        while (!done_o) tick();
        descriptor_i.valid        <= 1'b1;
        descriptor_i.base_address <= base;
        tick();
        descriptor_i.valid <= 1'b0;
        repeat (2) tick();
        assert (!done_o) else fail_run("done_o did not fall within two cycles of a descriptor");
    endtask

    task automatic run_stride(input stride_pkg::addr_t base, input stride_pkg::stride_cfg_t cfg);
        queue_expected(base, cfg);
        send_descriptor(base);
        while (!done_o) tick();
        assert (expected_q.size() == 0)
            else fail_run($sformatf("%0d expected requests never arrived", expected_q.size()));
    endtask

    // ----------------------------------------------------------
    // Request checking
    // ----------------------------------------------------------
    // Head mirror lags the queue by one edge, in step with the output register
    always @(posedge ap_clk) begin
        if (!areset_csr_engine && request_memory_o.valid && expected_q.size() != 0) begin
            void'(expected_q.pop_front());
        end
        exp_count <= expected_q.size();
        exp_head  <= (expected_q.size() != 0) ? expected_q[0] : '0;
    end

    a_req_expected : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        request_memory_o.valid |-> (exp_count != 0)
    ) else fail_run("A request arrived while none was expected");

    a_req_seq : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        request_memory_o.valid |-> (request_memory_o.payload.seq == exp_head.seq)
    ) else report_mismatch("request_memory_o.payload.seq",
                           64'($sampled(request_memory_o.payload.seq)),
                           64'($sampled(exp_head.seq)));

    a_req_address : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        request_memory_o.valid |-> (request_memory_o.payload.address == exp_head.address)
    ) else report_mismatch("request_memory_o.payload.address",
                           64'($sampled(request_memory_o.payload.address)),
                           64'($sampled(exp_head.address)));

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles before the tests finished",
                               TIMEOUT_CYCLES));
        end
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        stride_pkg::stride_cfg_t cfg_a;
        stride_pkg::stride_cfg_t cfg_b;
        void'($urandom(79));
        descriptor_i      <= '0;
        response_memory_i <= '0;
        request_rd_en_i   <= 1'b0;
        tick();
        while (areset_csr_engine) tick();
        repeat (3) tick();

        // Idle outputs after reset
        assert (done_o === 1'b1) else report_mismatch("done_o", 64'(done_o), 64'd1);
        assert (request_memory_o.valid === 1'b0)
            else report_mismatch("request_memory_o.valid", 64'(request_memory_o.valid), 64'd0);
        assert (response_ready_o === 1'b1)
            else report_mismatch("response_ready_o", 64'(response_ready_o), 64'd1);

        // Single run
        cfg_a = make_cfg(10, 3, 20);
        send_config(cfg_a);
        run_stride(32'h1000_0000, cfg_a);

        // Consumer stalls about half the time
        cfg_a = make_cfg(100, 7, 200);
        send_config(cfg_a);
        rd_random = 1'b1;
        run_stride(32'h2000_0400, cfg_a);
        rd_random = 1'b0;

        // Zero count
        cfg_a = make_cfg(5, 2, 0);
        send_config(cfg_a);
        run_stride(32'h3000_0000, cfg_a);

        // Two configurations queued ahead of two descriptors
        cfg_a = make_cfg($urandom_range(1000, 0), $urandom_range(16, 1), $urandom_range(40, 1));
        cfg_b = make_cfg($urandom_range(1000, 0), $urandom_range(16, 1), $urandom_range(40, 1));
        send_config(cfg_a);
        send_config(cfg_b);
        run_stride($urandom, cfg_a);
        run_stride($urandom, cfg_b);

        repeat (4) tick();
        if (expected_q.size() == 0 && done_o) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_run("Run ended with requests outstanding or the engine still busy");
        end
    end

endmodule

// ==== flist.f ====
verilog/stride_pkg.sv
verilog/stride_fifo.sv
verilog/stride_configure.sv
verilog/stride_generator.sv
verilog/engine_stride_index.sv
testbench/tb_clock_gen.sv
testbench/tb_engine_stride_index.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -sv -Wno-fatal \
    --top-module tb_engine_stride_index \
    -f flist.f \
    -o sim_engine_stride_index

./obj_dir/sim_engine_stride_index | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    exit 0
else
    exit 1
fi
